//--- logic/periph_settings.svh
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Core bus and pin widths
`define PERIPH_ADDR_W 11
`define PERIPH_DATA_W 32
`define PERIPH_PINS 8

// Slot map, 64 byte full slots and 16 byte byte slots
`define FULL_SLOTS 16
`define BYTE_SLOTS 16
`define FULL_SLOT_GPIO 4'd1
`define FULL_SLOT_PWM 4'd2
`define BYTE_SLOT_EDGE 4'd0

// GPIO register offsets within its full slot
`define GPIO_OFS_OUT 6'h00
`define GPIO_OFS_IN 6'h04
`define GPIO_OFS_AUDIO 6'h10
`define GPIO_OFS_FUNC_BASE 6'h20 // 0x20..0x3C, one word per pin

// PWM register offsets
`define PWM_OFS_PERIOD 6'h00
`define PWM_OFS_DUTY 6'h04
`define PWM_OFS_STATUS 6'h08

// Edge counter register offsets
`define EDGE_OFS_COUNT 4'h0
`define EDGE_OFS_PIN 4'h1

// Pin function select, bit 4 picks a byte slot, bits 3..0 the slot index
`define FUNC_SEL_W 6

`endif

//--- logic/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // Access size as driven by the core on read_n / write_n
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11  // No request this cycle
    } access_e;

    // Source feeding the registered audio output
    // Codes above AUD_GPIO7 all give a constant zero
    typedef enum logic [2:0] {
        AUD_PWM   = 3'd0,  // PWM generator pin 0
        AUD_EDGE  = 3'd1,  // Edge counter pin 0
        AUD_GPIO7 = 3'd2,  // GPIO output bit 7
        AUD_ZERO  = 3'd3
    } audio_src_e;

endpackage

`default_nettype wire

//--- logic/periph_bus.sv
`default_nettype none
`timescale 1ns/100ps
`include "periph_settings.svh"

module periph_bus import periph_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire [`PERIPH_ADDR_W-1:0]   i_addr,
    input  wire access_e               i_write_n,
    input  wire access_e               i_read_n,
    input  wire                        i_read_complete,

    // Per-slot read data back from the peripherals
    input  wire [`PERIPH_DATA_W-1:0]   i_gpio_rdata,
    input  wire [`PERIPH_DATA_W-1:0]   i_pwm_rdata,
    input  wire                        i_pwm_ready,
    input  wire [7:0]                  i_edge_rdata,

    output logic [`FULL_SLOTS-1:0]     o_full_sel,
    output logic [`BYTE_SLOTS-1:0]     o_byte_sel,
    output access_e                    o_peri_read_n,

    output logic [`PERIPH_DATA_W-1:0]  o_rdata,
    output logic                       o_ready
);

    logic [`PERIPH_DATA_W-1:0] peri_data;    // Data from the addressed slot
    logic                      peri_ready;
    logic [`PERIPH_DATA_W-1:0] rdata_q;      // Hold register toward the core
    logic                      hold_q;       // Hold register holds a result
    logic                      ready_q;
    logic                      read_req;

    assign read_req = (i_read_n != ACC_NONE);

    // Slot decode and read mux
    always_comb begin
        o_full_sel = '0;
        o_byte_sel = '0;
        peri_data  = '0;
        peri_ready = 1'b1;  // Empty slots answer at once with zero

        if (i_addr[10:9] == 2'b10) begin
            o_byte_sel[i_addr[7:4]] = 1'b1;
            if (i_addr[7:4] == `BYTE_SLOT_EDGE) begin
                peri_data = {{(`PERIPH_DATA_W-8){1'b0}}, i_edge_rdata};
            end
        end else begin
            // Upper full slots are not decoded, bit 10 is ignored here
            o_full_sel[i_addr[9:6]] = 1'b1;
            case (i_addr[9:6])
                `FULL_SLOT_GPIO: begin
                    peri_data = i_gpio_rdata;
                end
                `FULL_SLOT_PWM: begin
                    peri_data  = i_pwm_rdata;
                    peri_ready = i_pwm_ready;
                end
                default: begin
                    peri_data = '0;
                end
            endcase
        end
    end

    // Once the result is registered, peripherals must not see the read again
    assign o_peri_read_n = access_e'(i_read_n | {2{ready_q}});

    // Capture once per read, release on read complete
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            if (!hold_q && peri_ready && read_req) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && peri_ready && !i_read_complete;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_q && peri_ready && read_req) begin
            rdata_q <= peri_data;
        end
    end

    assign o_rdata = rdata_q;
    assign o_ready = ready_q || (i_write_n != ACC_NONE);  // Writes finish in the same cycle

endmodule

`default_nettype wire

//--- logic/gpio_ctrl.sv
`default_nettype none
`timescale 1ns/100ps
`include "periph_settings.svh"

module gpio_ctrl import periph_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire                        i_sel,
    input  wire [5:0]                  i_addr_ofs,
    input  wire [7:0]                  i_wdata,
    input  wire access_e               i_write_n,

    input  wire [`PERIPH_PINS-1:0]     i_ui_in,
    input  wire [`PERIPH_PINS-1:0]     i_pwm_pins,
    input  wire [`PERIPH_PINS-1:0]     i_edge_pins,

    output logic [`PERIPH_DATA_W-1:0]  o_rdata,
    output logic [`PERIPH_PINS-1:0]    o_uo_out,
    output logic                       o_audio,
    output logic                       o_audio_select
);

    localparam int FUNC_BYTE_BIT = 4;
    localparam int DW = `PERIPH_DATA_W;

    logic [`PERIPH_PINS-1:0] gpio_out;
    logic [`FUNC_SEL_W-1:0]  func_sel [`PERIPH_PINS];
    logic [3:0]              audio_sel;
    logic                    wr_en;
    logic                    func_hit;
    logic [2:0]              func_idx;

    assign wr_en    = i_sel && (i_write_n != ACC_NONE);
    assign func_hit = (i_addr_ofs & 6'h23) == `GPIO_OFS_FUNC_BASE;  // 0x20..0x3C, word aligned
    assign func_idx = i_addr_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
            for (int p = 0; p < `PERIPH_PINS; p++) begin
                func_sel[p] <= {2'b00, `FULL_SLOT_GPIO};  // All pins start as plain GPIO
            end
        end else if (wr_en) begin
            if (i_addr_ofs == `GPIO_OFS_OUT) begin
                gpio_out <= i_wdata;
            end
            if (i_addr_ofs == `GPIO_OFS_AUDIO) begin
                audio_sel <= i_wdata[3:0];
            end
            if (func_hit) begin
                func_sel[func_idx] <= i_wdata[`FUNC_SEL_W-1:0];
            end
        end
    end

    // Register readback
    always_comb begin
        o_rdata = '0;
        case (i_addr_ofs)
            `GPIO_OFS_OUT:   o_rdata = {{(DW-8){1'b0}}, gpio_out};
            `GPIO_OFS_IN:    o_rdata = {{(DW-8){1'b0}}, i_ui_in};
            `GPIO_OFS_AUDIO: o_rdata = {{(DW-4){1'b0}}, audio_sel};
            default: begin
                if (func_hit) begin
                    o_rdata = {{(DW-`FUNC_SEL_W){1'b0}}, func_sel[func_idx]};
                end
            end
        endcase
    end

    // Per-pin output mux
    always_comb begin
        for (int p = 0; p < `PERIPH_PINS; p++) begin
            o_uo_out[p] = 1'b0;
            if (func_sel[p][FUNC_BYTE_BIT]) begin
                if (func_sel[p][3:0] == `BYTE_SLOT_EDGE) begin
                    o_uo_out[p] = i_edge_pins[p];
                end
            end else begin
                case (func_sel[p][3:0])
                    `FULL_SLOT_GPIO: o_uo_out[p] = gpio_out[p];
                    `FULL_SLOT_PWM:  o_uo_out[p] = i_pwm_pins[p];
                    default:         o_uo_out[p] = 1'b0;
                endcase
            end
        end
    end

    // Audio is one register behind its source
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_audio <= 1'b0;
        end else begin
            case (audio_src_e'(audio_sel[2:0]))
                AUD_PWM:   o_audio <= i_pwm_pins[0];
                AUD_EDGE:  o_audio <= i_edge_pins[0];
                AUD_GPIO7: o_audio <= gpio_out[7];
                default:   o_audio <= 1'b0;
            endcase
        end
    end

    assign o_audio_select = audio_sel[3];

endmodule

`default_nettype wire

//--- logic/pwm_gen.sv
`default_nettype none
`timescale 1ns/100ps
`include "periph_settings.svh"

module pwm_gen import periph_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire                        i_sel,
    input  wire [5:0]                  i_addr_ofs,
    input  wire [7:0]                  i_wdata,
    input  wire access_e               i_write_n,
    input  wire access_e               i_read_n,

    output logic [`PERIPH_DATA_W-1:0]  o_rdata,
    output logic                       o_ready,
    output logic [`PERIPH_PINS-1:0]    o_pins,
    output logic                       o_irq
);

    logic [7:0]                period_q;
    logic [7:0]                duty_q;
    logic [7:0]                count_q;
    logic                      irq_q;
    logic                      ready_q;
    logic [`PERIPH_DATA_W-1:0] rdata_q;
    logic                      wr_en;
    logic                      rd_en;
    logic                      wrap;

    assign wr_en = i_sel && (i_write_n != ACC_NONE);
    assign rd_en = i_sel && (i_read_n != ACC_NONE);
    assign wrap  = (count_q >= period_q);  // Also catches a period lowered below the count

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            period_q <= '0;
            duty_q   <= '0;
            count_q  <= '0;
            irq_q    <= 1'b0;
            ready_q  <= 1'b0;
        end else begin
            ready_q <= rd_en;                    // Answer one cycle after the request
            count_q <= wrap ? 8'd0 : count_q + 8'd1;

            if (wr_en && i_addr_ofs == `PWM_OFS_PERIOD) begin
                period_q <= i_wdata;
            end
            if (wr_en && i_addr_ofs == `PWM_OFS_DUTY) begin
                duty_q <= i_wdata;
            end

            // Status write wins over a wrap in the same cycle
            if (wr_en && i_addr_ofs == `PWM_OFS_STATUS) begin
                irq_q <= 1'b0;
            end else if (wrap) begin
                irq_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            case (i_addr_ofs)
                `PWM_OFS_PERIOD: rdata_q <= {{(`PERIPH_DATA_W-8){1'b0}}, period_q};
                `PWM_OFS_DUTY:   rdata_q <= {{(`PERIPH_DATA_W-8){1'b0}}, duty_q};
                `PWM_OFS_STATUS: rdata_q <= {{(`PERIPH_DATA_W-1){1'b0}}, irq_q};
                default:         rdata_q <= '0;
            endcase
        end
    end

    assign o_rdata = rdata_q;
    assign o_ready = ready_q;
    assign o_pins  = {`PERIPH_PINS{count_q < duty_q}};  // Same level on every pin
    assign o_irq   = irq_q;

endmodule

`default_nettype wire

//--- logic/edge_counter.sv
`default_nettype none
`timescale 1ns/100ps
`include "periph_settings.svh"

module edge_counter (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire                      i_write,     // Already qualified by the slot select
    input  wire [3:0]                i_addr_ofs,
    input  wire [7:0]                i_wdata,
    input  wire [`PERIPH_PINS-1:0]   i_ui_in,

    output logic [7:0]               o_rdata,
    output logic [`PERIPH_PINS-1:0]  o_pins
);

    localparam int SEL_W = $clog2(`PERIPH_PINS);

    logic [SEL_W-1:0] pin_sel_q;
    logic             prev_q;
    logic [7:0]       count_q;
    logic             pin_now;
    logic             rise;

    assign pin_now = i_ui_in[pin_sel_q];
    assign rise    = pin_now && !prev_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sel_q <= '0;
            prev_q    <= 1'b0;
            count_q   <= '0;
        end else begin
            prev_q <= pin_now;
            if (i_write && i_addr_ofs == `EDGE_OFS_COUNT) begin
                count_q <= '0;
            end else if (rise) begin
                count_q <= count_q + 8'd1;   // Wraps at 256
            end
            if (i_write && i_addr_ofs == `EDGE_OFS_PIN) begin
                pin_sel_q <= i_wdata[SEL_W-1:0];
                // Track the new pin so switching does not look like an edge
                prev_q    <= i_ui_in[i_wdata[SEL_W-1:0]];
            end
        end
    end

    always_comb begin
        case (i_addr_ofs)
            `EDGE_OFS_COUNT: o_rdata = count_q;
            `EDGE_OFS_PIN:   o_rdata = {{(8-SEL_W){1'b0}}, pin_sel_q};
            default:         o_rdata = '0;
        endcase
    end

    assign o_pins = count_q;

endmodule

`default_nettype wire

//--- logic/periph_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "periph_settings.svh"

module periph_top import periph_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire [`PERIPH_PINS-1:0]     i_ui_in,
    output logic [`PERIPH_PINS-1:0]    o_uo_out,
    output logic                       o_audio,
    output logic                       o_audio_select,

    // Core bus
    input  wire [`PERIPH_ADDR_W-1:0]   i_addr,
    input  wire [`PERIPH_DATA_W-1:0]   i_wdata,
    input  wire access_e               i_write_n,
    input  wire access_e               i_read_n,
    input  wire                        i_read_complete,
    output logic [`PERIPH_DATA_W-1:0]  o_rdata,
    output logic                       o_ready,

    output logic                       o_pwm_irq
);

    logic [`FULL_SLOTS-1:0]     full_sel;
    logic [`BYTE_SLOTS-1:0]     byte_sel;
    access_e                    peri_read_n;
    logic [`PERIPH_DATA_W-1:0]  gpio_rdata;
    logic [`PERIPH_DATA_W-1:0]  pwm_rdata;
    logic                       pwm_ready;
    logic [`PERIPH_PINS-1:0]    pwm_pins;
    logic [7:0]                 edge_rdata;
    logic [`PERIPH_PINS-1:0]    edge_pins;
    logic                       edge_write;

    assign edge_write = (i_write_n != ACC_NONE) && byte_sel[`BYTE_SLOT_EDGE];

    periph_bus u_periph_bus (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (i_addr),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .i_gpio_rdata    (gpio_rdata),
        .i_pwm_rdata     (pwm_rdata),
        .i_pwm_ready     (pwm_ready),
        .i_edge_rdata    (edge_rdata),
        .o_full_sel      (full_sel),
        .o_byte_sel      (byte_sel),
        .o_peri_read_n   (peri_read_n),
        .o_rdata         (o_rdata),
        .o_ready         (o_ready)
    );

    gpio_ctrl u_gpio_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_sel          (full_sel[`FULL_SLOT_GPIO]),
        .i_addr_ofs     (i_addr[5:0]),
        .i_wdata        (i_wdata[7:0]),
        .i_write_n      (i_write_n),
        .i_ui_in        (i_ui_in),
        .i_pwm_pins     (pwm_pins),
        .i_edge_pins    (edge_pins),
        .o_rdata        (gpio_rdata),
        .o_uo_out       (o_uo_out),
        .o_audio        (o_audio),
        .o_audio_select (o_audio_select)
    );

    pwm_gen u_pwm_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (full_sel[`FULL_SLOT_PWM]),
        .i_addr_ofs (i_addr[5:0]),
        .i_wdata    (i_wdata[7:0]),
        .i_write_n  (i_write_n),
        .i_read_n   (peri_read_n),   // Masked while the bus holds a result
        .o_rdata    (pwm_rdata),
        .o_ready    (pwm_ready),
        .o_pins     (pwm_pins),
        .o_irq      (o_pwm_irq)
    );

    edge_counter u_edge_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_write    (edge_write),
        .i_addr_ofs (i_addr[3:0]),
        .i_wdata    (i_wdata[7:0]),
        .i_ui_in    (i_ui_in),
        .o_rdata    (edge_rdata),
        .o_pins     (edge_pins)
    );

endmodule

`default_nettype wire

//--- dv/periph_sva.sv
`default_nettype none
`timescale 1ns/100ps
`include "periph_settings.svh"

module periph_sva import periph_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    input  access_e                    i_write_n,
    input  access_e                    i_read_n,
    input  wire                        i_read_complete,
    input  wire                        i_ready,
    input  wire                        i_hold,
    input  wire [`PERIPH_DATA_W-1:0]   i_rdata_hold
);

    int fail_count = 0;

    // Bus comes out of reset idle with an empty hold register
    a_reset_ready: assert property (@(posedge clk)
        !rst_n |=> !i_hold && ((i_write_n != ACC_NONE) || !i_ready))
        else begin
            fail_count++;
            $error("bus not idle after reset");
        end

    a_read_ready: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_read_n != ACC_NONE) |-> ##[1:2] i_ready)
        else begin
            fail_count++;
            $error("read not ready within 2 cycles");
        end

    // Data shown to the core stays put while the read is still open
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        i_ready && (i_read_n != ACC_NONE) && !i_read_complete |=> $stable(i_rdata_hold))
        else begin
            fail_count++;
            $error("read data changed before read complete");
        end

endmodule

bind periph_bus periph_sva u_periph_sva (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_write_n       (i_write_n),
    .i_read_n        (i_read_n),
    .i_read_complete (i_read_complete),
    .i_ready         (o_ready),
    .i_hold          (hold_q),
    .i_rdata_hold    (rdata_q)
);

`default_nettype wire

//--- dv/periph_checker.sv
`default_nettype none
`timescale 1ns/100ps
`include "periph_settings.svh"

module periph_checker import periph_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,

    input  access_e                    i_read_n,
    input  wire                        i_read_complete,
    input  wire [`PERIPH_DATA_W-1:0]   i_rdata,
    input  wire                        i_ready,
    input  wire [`PERIPH_PINS-1:0]     i_uo_out,
    input  wire                        i_audio,
    input  wire                        i_audio_select,
    input  wire                        i_pwm_irq,

    input  wire                        i_exp_valid,
    input  wire [`PERIPH_DATA_W-1:0]   i_exp_rdata,
    input  wire                        i_chk_en,
    input  wire                        i_chk_kind,
    input  wire [7:0]                  i_chk_mask,
    input  wire [7:0]                  i_chk_val,

    output int                         o_errors,
    output int                         o_checks
);

    int         err_count = 0;
    int         chk_count = 0;
    logic [7:0] observed;

    // Pin vector, or {irq, audio_select, audio} in the low bits
    assign observed = i_chk_kind ? {5'b0, i_pwm_irq, i_audio_select, i_audio} : i_uo_out;

    always @(posedge clk) begin
        if (rst_n && i_exp_valid && i_ready && i_read_n != ACC_NONE && !i_read_complete) begin
            chk_count = chk_count + 1;
            if (i_rdata !== i_exp_rdata) begin
                $display("ERROR @ %0t: read data %08h, expected %08h",
                         $time, i_rdata, i_exp_rdata);
                err_count = err_count + 1;
            end
        end
        if (rst_n && i_chk_en) begin
            chk_count = chk_count + 1;
            if ((observed & i_chk_mask) !== (i_chk_val & i_chk_mask)) begin
                $display("ERROR @ %0t: %s is %02h under mask %02h, expected %02h", $time,
                         i_chk_kind ? "irq/audio" : "uo_out", observed, i_chk_mask, i_chk_val);
                err_count = err_count + 1;
            end
        end
    end

    assign o_errors = err_count;
    assign o_checks = chk_count;

endmodule

`default_nettype wire

//--- dv/periph_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "periph_settings.svh"

module periph_tb import periph_pkg::*; ();

    localparam int    MAX_LINES = 96;
    localparam int    NF        = 6;   // Fields per stimulus line
    localparam string STIM_FILE = "dv/periph_input.txt";

    logic                       clk;
    logic                       rst_n;
    logic [`PERIPH_PINS-1:0]    ui_in;
    logic [`PERIPH_ADDR_W-1:0]  addr;
    logic [`PERIPH_DATA_W-1:0]  wdata;
    access_e                    write_n;
    access_e                    read_n;
    logic                       read_complete;

    wire [`PERIPH_PINS-1:0]     uo_out;
    wire                        audio;
    wire                        audio_select;
    wire [`PERIPH_DATA_W-1:0]   rdata;
    wire                        ready;
    wire                        pwm_irq;

    // Expectations handed to the checker
    logic                       exp_valid;
    logic [`PERIPH_DATA_W-1:0]  exp_rdata;
    logic                       chk_en;
    logic                       chk_kind;   // 0 uo_out, 1 irq/audio
    logic [7:0]                 chk_mask;
    logic [7:0]                 chk_val;
    int                         errors;
    int                         checks;

    logic [31:0] stim [MAX_LINES*NF];
    int          n_lines;
    int          max_wait;
    int          bad_lines   = 0;
    int          cycle_count = 0;
    int          cycle_limit = 100000;

    periph_top u_periph_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .o_uo_out        (uo_out),
        .o_audio         (audio),
        .o_audio_select  (audio_select),
        .i_addr          (addr),
        .i_wdata         (wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .o_rdata         (rdata),
        .o_ready         (ready),
        .o_pwm_irq       (pwm_irq)
    );

    periph_checker u_periph_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .i_rdata         (rdata),
        .i_ready         (ready),
        .i_uo_out        (uo_out),
        .i_audio         (audio),
        .i_audio_select  (audio_select),
        .i_pwm_irq       (pwm_irq),
        .i_exp_valid     (exp_valid),
        .i_exp_rdata     (exp_rdata),
        .i_chk_en        (chk_en),
        .i_chk_kind      (chk_kind),
        .i_chk_mask      (chk_mask),
        .i_chk_val       (chk_val),
        .o_errors        (errors),
        .o_checks        (checks)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog on the total run length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic run_line(input int idx);
        logic [31:0] op;
        logic [31:0] exp;
        int          b;
        int          gap;
        b   = idx * NF;
        op  = stim[b+1];
        exp = stim[b+5];
        gap = int'($urandom % 3);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        ui_in <= stim[b][7:0];
        case (op)
            32'h0: begin
                addr    <= stim[b+2][`PERIPH_ADDR_W-1:0];
                wdata   <= stim[b+4];
                write_n <= access_e'(stim[b+3][1:0]);
                @(posedge clk);
                write_n <= ACC_NONE;
            end
            32'h1: begin
                addr      <= stim[b+2][`PERIPH_ADDR_W-1:0];
                read_n    <= access_e'(stim[b+3][1:0]);
                exp_rdata <= exp;
                exp_valid <= 1'b1;
                do @(posedge clk); while (!ready);
                read_complete <= 1'b1;   // Same cycle as o_ready, then drop the request
                read_n        <= ACC_NONE;
                exp_valid     <= 1'b0;
                @(posedge clk);
                read_complete <= 1'b0;
            end
            32'h2: begin
                repeat (stim[b+4]) @(posedge clk);
            end
            32'h3, 32'h4: begin
                chk_en   <= 1'b1;
                chk_kind <= (op == 32'h4);
                chk_mask <= exp[15:8];
                chk_val  <= exp[7:0];
                @(posedge clk);
                chk_en   <= 1'b0;
            end
            default: begin
                $display("Stimulus line %0d has an unknown operation %0h", idx, op);
                bad_lines++;
            end
        endcase
    endtask

    initial begin
        int i;
        int sva_fails;
        void'($urandom(32'h2280));
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        wdata         = '0;
        write_n       = ACC_NONE;
        read_n        = ACC_NONE;
        read_complete = 1'b0;
        exp_valid     = 1'b0;
        exp_rdata     = '0;
        chk_en        = 1'b0;
        chk_kind      = 1'b0;
        chk_mask      = '0;
        chk_val       = '0;

        for (i = 0; i < MAX_LINES*NF; i++) begin
            stim[i] = 32'hDEAD_0000 | i;
        end
        $readmemh(STIM_FILE, stim);

        // Count lines up to the end marker and find the longest wait
        n_lines  = 0;
        max_wait = 0;
        while (n_lines < MAX_LINES && stim[n_lines*NF+1] != 32'hF) begin
            if (stim[n_lines*NF+1] == 32'h2 && int'(stim[n_lines*NF+4]) > max_wait) begin
                max_wait = int'(stim[n_lines*NF+4]);
            end
            n_lines++;
        end
        cycle_limit = 20 * n_lines + max_wait;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (i = 0; i < n_lines; i++) begin
            run_line(i);
        end
        repeat (4) @(posedge clk);

        sva_fails = u_periph_top.u_periph_bus.u_periph_sva.fail_count;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures, %0d bad lines",
                 checks, errors, sva_fails, bad_lines);
        if (errors == 0 && sva_fails == 0 && bad_lines == 0 && n_lines > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/periph_input.txt
// Columns: ui_in op addr size wdata expected
// op 0 write, 1 read, 2 wait wdata cycles, 3 check uo_out, 4 check {irq,audio_sel,audio}, F end
00 1 040 2 00000000 00000000
00 1 050 2 00000000 00000000
00 1 060 2 00000000 00000001
00 1 07C 2 00000000 00000001
00 3 000 0 00000000 0000FF00
00 0 040 2 000000A5 00000000
00 1 040 2 00000000 000000A5
00 3 000 0 00000000 0000FFA5
3C 1 044 2 00000000 0000003C
3C 1 000 2 00000000 00000000
3C 1 140 2 00000000 00000000
3C 1 430 0 00000000 00000000
3C 0 060 2 00000010 00000000
3C 0 064 2 00000010 00000000
3C 0 068 2 00000010 00000000
3C 0 06C 2 00000010 00000000
3C 0 400 0 00000000 00000000
3D 2 000 0 00000002 00000000
3C 2 000 0 00000002 00000000
3D 2 000 0 00000002 00000000
3C 2 000 0 00000002 00000000
3D 2 000 0 00000002 00000000
3C 2 000 0 00000002 00000000
3C 3 000 0 00000000 0000FFA3
3C 1 400 0 00000000 00000003
3C 0 400 0 00000000 00000000
3C 1 400 0 00000000 00000000
3C 3 000 0 00000000 0000FFA0
3C 0 070 2 00000002 00000000
3C 3 000 0 00000000 0000FFA0
3C 0 080 2 00000010 00000000
3C 0 084 2 00000020 00000000
3C 3 000 0 00000000 0000FFB0
3C 1 080 2 00000000 00000010
3C 1 084 2 00000000 00000020
3C 0 084 2 00000000 00000000
3C 3 000 0 00000000 0000FFA0
3C 0 080 2 00000000 00000000
3C 0 080 2 000000FF 00000000
3C 0 088 2 00000000 00000000
3C 4 000 0 00000000 00000700
3C 1 088 2 00000000 00000000
3C 2 000 0 00000110 00000000
3C 1 088 2 00000000 00000001
3C 4 000 0 00000000 00000704
3C 0 088 2 00000000 00000000
3C 4 000 0 00000000 00000700
3C 0 080 2 00000010 00000000
3C 0 084 2 00000020 00000000
3C 2 000 0 00000004 00000000
3C 4 000 0 00000000 00000301
3C 0 050 2 00000001 00000000
3C 2 000 0 00000004 00000000
3C 4 000 0 00000000 00000300
3D 2 000 0 00000002 00000000
3C 2 000 0 00000002 00000000
3C 4 000 0 00000000 00000301
3C 0 050 2 0000000A 00000000
3C 2 000 0 00000004 00000000
3C 4 000 0 00000000 00000303
3C 1 050 2 00000000 0000000A
00 F 000 0 00000000 00000000

//--- sources.f
+incdir+logic
logic/periph_pkg.sv
logic/periph_bus.sv
logic/gpio_ctrl.sv
logic/pwm_gen.sv
logic/edge_counter.sv
logic/periph_top.sv
dv/periph_sva.sv
dv/periph_checker.sv
dv/periph_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= periph_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS   ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
